//--- logic/x1_io_pkg.sv
`default_nettype none

package x1_io_pkg;

	// --------------------------------------------------------------------------
	// bus types
	// --------------------------------------------------------------------------
	typedef logic [15:0] addr_t;	// z80 i/o address, full 16 bits on the bus
	typedef logic [7:0]  data_t;	// bus data byte

	// i/o page decode, upper address byte only
	localparam logic [7:0] IO_PAGE_PIA = 8'h1A;	// 8255 at 1a00..1a03
	localparam logic [7:0] IO_PAGE_SPI = 8'h0E;	// ext rom page, mmc shifter sits here

	// --------------------------------------------------------------------------
	// clock generator
	// --------------------------------------------------------------------------
	localparam int PRESCALE_BITS = 4;	// reset held until this wraps
	localparam int CPU_DIV_BITS  = 3;	// 32M / 8 = 4M cpu clock

	// phase points of the cpu divider
	localparam logic [CPU_DIV_BITS-1:0] CPU_RISE_PHASE = 3'd6;
	localparam logic [CPU_DIV_BITS-1:0] CPU_FALL_PHASE = 3'd2;

	// --------------------------------------------------------------------------
	// enums
	// --------------------------------------------------------------------------
	// 8255 register select, a1:a0
	typedef enum logic [1:0] {
		PIA_PORT_A = 2'd0,	// printer data out
		PIA_PORT_B = 2'd1,	// status in
		PIA_PORT_C = 2'd2,	// control levels out
		PIA_CTRL   = 2'd3	// mode / bit set-reset
	} pia_reg_t;

	// mmc shifter
	typedef enum logic {
		SPI_IDLE  = 1'b0,
		SPI_SHIFT = 1'b1
	} spi_state_t;

endpackage

`default_nettype wire

//--- logic/clock_reset_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_reset_gen
	import x1_io_pkg::*;
(
	input  wire  clk32M,	// master clock
	input  wire  clk_reset,	// hardware reset, async
	input  wire  ipl_n,		// ipl button, low forces reset
	output logic sys_reset,	// delayed system reset
	output logic cpu_clk,	// 4MHz cpu clock level
	output logic cpu_rise,	// one-cycle strobe, cpu clock about to rise
	output logic cpu_fall,	// one-cycle strobe, cpu clock about to fall
	output logic clk2m		// 2MHz square wave
);

	logic [PRESCALE_BITS-1:0] prescale;	// free running
	logic [3:0]               clk_div;	// 2M divider, msb is the output
	logic [CPU_DIV_BITS-1:0]  cpu_div;	// cpu phase counter
	logic                     reset_dly;

	// --------------------------------------------------------------------------
	// prescaler and delayed reset
	// --------------------------------------------------------------------------
	always_ff @(posedge clk32M or posedge clk_reset)
	begin
		if (clk_reset)
		begin
			prescale  <= '0;
			reset_dly <= 1'b1;
		end
		else
		begin
			prescale <= prescale + 1'b1;
			if (prescale == {PRESCALE_BITS{1'b1}})	// first wrap releases
				reset_dly <= 1'b0;
		end
	end

	assign sys_reset = reset_dly | ~ipl_n;	// ipl button forces it back on

	// --------------------------------------------------------------------------
	// cpu clock and 2M
	// --------------------------------------------------------------------------
	always_ff @(posedge clk32M or posedge clk_reset)
	begin
		if (clk_reset)
		begin
			clk_div  <= '0;
			cpu_div  <= '0;
			cpu_rise <= 1'b0;
			cpu_fall <= 1'b0;
			cpu_clk  <= 1'b0;
		end
		else
		begin
			clk_div <= clk_div + 4'd1;
			cpu_div <= cpu_rise ? '0 : cpu_div + 1'b1;	// restart on rise
			cpu_rise <= (cpu_div == CPU_RISE_PHASE);
			cpu_fall <= (cpu_div == CPU_FALL_PHASE);
			if (cpu_rise)
				cpu_clk <= 1'b1;
			else if (cpu_fall)
				cpu_clk <= 1'b0;
		end
	end

	assign clk2m = clk_div[3];	// toggles every 8 clocks

endmodule

`default_nettype wire

//--- logic/pia_port.sv
`timescale 1ns/10ps
`default_nettype none

module pia_port
	import x1_io_pkg::*;
(
	input  wire           clk32M,
	input  wire           sys_reset,
	input  wire           pia_cs,		// page decode, already qualified by iorq
	input  wire pia_reg_t addr_low,		// a1:a0
	input  wire data_t    wdata,
	input  wire           rd,
	input  wire           wr,
	input  wire data_t    status,		// port b pins, packed by the top
	output data_t         pia_rdata,
	output data_t         printer_data,	// port a
	output logic          lpt_stb,		// pc7
	output logic          width40,		// pc6, 40 column text
	output logic          dam_en_n,		// pc5, simultaneous access request
	output logic          sm_scrl_n		// pc4, smooth scroll
);

	data_t port_a;		// printer latch
	data_t port_c;		// control latch
	data_t reg_rdata;	// selected register
	logic  wr_en;
	logic  rd_en;

	assign wr_en = pia_cs & wr;
	assign rd_en = pia_cs & rd;

	// --------------------------------------------------------------------------
	// write side, mode 0 only
	// --------------------------------------------------------------------------
	always_ff @(posedge clk32M or posedge sys_reset)
	begin
		if (sys_reset)
		begin
			port_a <= '0;
			port_c <= '0;
		end
		else if (wr_en)
		begin
			case (addr_low)
				PIA_PORT_A: port_a <= wdata;
				PIA_PORT_C: port_c <= wdata;
				PIA_CTRL:
				begin
					// bit set/reset word, d3:d1 picks the bit, d0 is the level
					if (!wdata[7])
						port_c[wdata[3:1]] <= wdata[0];
					// mode words are accepted and ignored
				end
				default: ;	// port b is input only
			endcase
		end
	end

	// --------------------------------------------------------------------------
	// read side
	// --------------------------------------------------------------------------
	always_comb
	begin
		case (addr_low)
			PIA_PORT_A: reg_rdata = port_a;	// latch readback
			PIA_PORT_B: reg_rdata = status;
			PIA_PORT_C: reg_rdata = port_c;
			default:    reg_rdata = 8'hff;	// control reg not readable
		endcase
	end

	assign pia_rdata = rd_en ? reg_rdata : 8'hff;

	assign printer_data = port_a;
	assign lpt_stb      = port_c[7];
	assign width40      = port_c[6];
	assign dam_en_n     = port_c[5];
	assign sm_scrl_n    = port_c[4];

endmodule

`default_nettype wire

//--- logic/mmc_spi_port.sv
`timescale 1ns/10ps
`default_nettype none

module mmc_spi_port
	import x1_io_pkg::*;
(
	input  wire        clk32M,
	input  wire        sys_reset,
	input  wire        spi_cs,		// ext rom page, iorq qualified
	input  wire  [6:0] addr_low,	// a6 no-load, a5:a4 select, a3:a0 count
	input  wire data_t wdata,
	input  wire        wr,
	input  wire        miso,		// card data out
	output data_t      spi_rdata,	// shift register
	output logic       spi_rdata_en,
	output logic       mmc_clk,
	output logic       mmc_cs_n,
	output logic       mmc_mosi,
	output logic       busy
);

	spi_state_t state;
	logic [3:0] bit_count;	// bits left to clock
	logic [1:0] sel;		// bit 1 mmc, bit 0 was the config rom
	data_t      sreg;
	data_t      load_data;
	logic       load;
	logic       miso_in;

	assign load      = spi_cs & wr;	// any write restarts the port
	assign load_data = addr_low[6] ? sreg : wdata;	// a6 set keeps old contents
	assign miso_in   = sel[1] & miso;	// deselected card reads as 0

	// --------------------------------------------------------------------------
	// shifter
	// --------------------------------------------------------------------------
	always_ff @(posedge clk32M or posedge sys_reset)
	begin
		if (sys_reset)
		begin
			state     <= SPI_IDLE;
			bit_count <= '0;
			sel       <= '0;
			sreg      <= '0;
			mmc_clk   <= 1'b0;
			mmc_mosi  <= 1'b0;
		end
		else if (load)
		begin
			bit_count <= addr_low[3:0];
			sel       <= addr_low[5:4];
			sreg      <= load_data;
			mmc_mosi  <= load_data[0];	// first bit set up before the first rise
			mmc_clk   <= 1'b0;
			state     <= (addr_low[3:0] != 4'd0) ? SPI_SHIFT : SPI_IDLE;
		end
		else if (state == SPI_SHIFT)
		begin
			mmc_clk <= ~mmc_clk;	// one toggle per clock
			if (!mmc_clk)
			begin
				// rising step, sample card, received bits enter at the top
				sreg <= {miso_in, sreg[7:1]};
			end
			else
			begin
				// falling step, next lsb goes out, count the bit
				mmc_mosi  <= sreg[0];
				bit_count <= bit_count - 4'd1;
				if (bit_count == 4'd1)
					state <= SPI_IDLE;	// 2 x count clocks in total
			end
		end
	end

	// --------------------------------------------------------------------------
	// outputs
	// --------------------------------------------------------------------------
	assign mmc_cs_n     = ~sel[1];
	assign spi_rdata    = sreg;
	assign spi_rdata_en = spi_cs & ~wr;	// reads of the page
	assign busy         = (state == SPI_SHIFT);

endmodule

`default_nettype wire

//--- logic/io_bus_select.sv
`timescale 1ns/10ps
`default_nettype none

module io_bus_select
	import x1_io_pkg::*;
#(
	parameter data_t BUS_FREE = 8'hff	// and tie, 8'h00 for an or tie
)
(
	input  wire addr_t addr,
	input  wire        iorq,
	input  wire        rd,
	input  wire data_t pia_rdata,
	input  wire data_t spi_rdata,
	input  wire        spi_rdata_en,
	output logic       pia_cs,
	output logic       spi_cs,
	output data_t      rdata
);

	logic [7:0] page;	// a15:a8
	logic       pia_hit;
	logic       spi_hit;
	logic       rd_spi;
	logic       rd_pia;

	// --------------------------------------------------------------------------
	// page decode
	// --------------------------------------------------------------------------
	assign page    = addr[15:8];
	assign pia_hit = (page == IO_PAGE_PIA);
	assign spi_hit = (page == IO_PAGE_SPI);

	// selects only while iorq, memory cycles on the same address never hit
	assign pia_cs = iorq & pia_hit;
	assign spi_cs = iorq & spi_hit;

	// --------------------------------------------------------------------------
	// read mux
	// --------------------------------------------------------------------------
	assign rd_spi = rd & spi_rdata_en;	// shift register wins
	assign rd_pia = rd & pia_cs;

	always_comb
	begin
		if (rd_spi)
			rdata = spi_rdata;
		else if (rd_pia)
			rdata = pia_rdata;
		else
			rdata = BUS_FREE;	// nobody drives
	end

endmodule

`default_nettype wire

//--- logic/x1_io_top.sv
`timescale 1ns/10ps
`default_nettype none

module x1_io_top
	import x1_io_pkg::*;
#(
	parameter data_t BUS_FREE = 8'hff	// idle bus value
)
(
	input  wire        clk32M,
	input  wire        clk_reset,
	input  wire        ipl_n,
	input  wire addr_t addr,
	input  wire data_t wdata,
	input  wire        iorq,
	input  wire        rd,
	input  wire        wr,
	input  wire        vblank_n,	// port b status pins
	input  wire        sub_tx_bsy,
	input  wire        sub_rx_bsy,
	input  wire        lpt_rdy,
	input  wire        vsync,
	input  wire        cmt_read,
	input  wire        key_brk_n,
	input  wire        miso,
	output data_t      rdata,
	output logic       sys_reset,
	output logic       cpu_clk,
	output logic       cpu_rise,
	output logic       cpu_fall,
	output logic       clk2m,
	output data_t      printer_data,
	output logic       lpt_stb,
	output logic       width40,
	output logic       dam_en_n,
	output logic       sm_scrl_n,
	output logic       mmc_clk,
	output logic       mmc_cs_n,
	output logic       mmc_mosi,
	output logic       spi_busy
);

	logic     pia_cs;
	logic     spi_cs;
	data_t    pia_rdata;
	data_t    spi_rdata;
	logic     spi_rdata_en;
	data_t    status;
	pia_reg_t pia_reg;

	// pb4 reads high on the plain x1
	assign status  = {vblank_n, sub_tx_bsy, sub_rx_bsy, 1'b1,
		lpt_rdy, vsync, cmt_read, key_brk_n};
	assign pia_reg = pia_reg_t'(addr[1:0]);

	// --------------------------------------------------------------------------
	// instances
	// --------------------------------------------------------------------------
	clock_reset_gen clock_reset_gen_i (
		.clk32M(clk32M), .clk_reset(clk_reset), .ipl_n(ipl_n),
		.sys_reset(sys_reset), .cpu_clk(cpu_clk), .cpu_rise(cpu_rise),
		.cpu_fall(cpu_fall), .clk2m(clk2m)
	);

	pia_port pia_port_i (
		.clk32M(clk32M), .sys_reset(sys_reset), .pia_cs(pia_cs),
		.addr_low(pia_reg), .wdata(wdata), .rd(rd), .wr(wr), .status(status),
		.pia_rdata(pia_rdata), .printer_data(printer_data), .lpt_stb(lpt_stb),
		.width40(width40), .dam_en_n(dam_en_n), .sm_scrl_n(sm_scrl_n)
	);

	mmc_spi_port mmc_spi_port_i (
		.clk32M(clk32M), .sys_reset(sys_reset), .spi_cs(spi_cs),
		.addr_low(addr[6:0]), .wdata(wdata), .wr(wr), .miso(miso),
		.spi_rdata(spi_rdata), .spi_rdata_en(spi_rdata_en), .mmc_clk(mmc_clk),
		.mmc_cs_n(mmc_cs_n), .mmc_mosi(mmc_mosi), .busy(spi_busy)
	);

	io_bus_select #(.BUS_FREE(BUS_FREE)) io_bus_select_i (
		.addr(addr), .iorq(iorq), .rd(rd), .pia_rdata(pia_rdata),
		.spi_rdata(spi_rdata), .spi_rdata_en(spi_rdata_en),
		.pia_cs(pia_cs), .spi_cs(spi_cs), .rdata(rdata)
	);

endmodule

`default_nettype wire

//--- verification/x1_io_checker.sv
`timescale 1ns/10ps
`default_nettype none

module x1_io_checker
	import x1_io_pkg::*;
(
	input  wire        clk32M,
	input  wire        clk_reset,
	input  wire        chk_stb,		// compare on this edge
	input  wire  [2:0] chk_view,	// which port group to look at
	input  wire data_t chk_exp,
	input  wire data_t measured,	// count or byte seen by the tb
	input  wire data_t rdata,
	input  wire data_t printer_data,
	input  wire        lpt_stb,
	input  wire        width40,
	input  wire        dam_en_n,
	input  wire        sm_scrl_n,
	input  wire        sys_reset,
	input  wire        mmc_cs_n,
	input  wire        cpu_clk,
	input  wire        cpu_rise,
	input  wire        cpu_fall,
	input  wire        clk2m,
	output int         mismatch_count
);

	data_t got;
	int    since_rise;	// edges since the last cpu_rise
	int    since_c2m;	// edges since clk2m last moved
	logic  c2m_q;
	logic  seen_rise;	// first period is not measured
	logic  seen_c2m;

	initial mismatch_count = 0;

	task automatic mismatch(input string msg);
		mismatch_count = mismatch_count + 1;
		$display("MISMATCH at %0t ns: %s", $time, msg);
	endtask

	// --------------------------------------------------------------------------
	// strobed compares of values settled since the falling edge
	// --------------------------------------------------------------------------
	always @(posedge clk32M)
	begin
		if (chk_stb)
		begin
			case (chk_view)
				3'd0:    got = rdata;
				3'd1:    got = printer_data;
				3'd2:    got = {4'h0, lpt_stb, width40, dam_en_n, sm_scrl_n};	// pc7..pc4
				3'd3:    got = {6'h00, mmc_cs_n, sys_reset};
				default: got = measured;	// mosi byte, pulse or edge count
			endcase
			if (got !== chk_exp)
				mismatch($sformatf("view %0d got %02h, expected %02h", chk_view, got, chk_exp));
		end
	end

	// clock strobes checked on every edge once reset is gone
	always @(posedge clk32M)
	begin
		if (clk_reset)
		begin
			since_rise = 0;
			since_c2m  = 0;
			c2m_q      = 1'b0;
			seen_rise  = 1'b0;
			seen_c2m   = 1'b0;
		end
		else
		begin
			since_rise = since_rise + 1;
			since_c2m  = since_c2m + 1;
			if (cpu_rise)
			begin
				if (seen_rise && since_rise != 8)
					mismatch($sformatf("cpu_rise period %0d, expected 8", since_rise));
				since_rise = 0;
				seen_rise  = 1'b1;
			end
			else if (since_rise > 8)
			begin
				mismatch("cpu_rise missing for more than 8 cycles");
				since_rise = 0;
			end
			if (cpu_fall && seen_rise && since_rise != 4)
				mismatch($sformatf("cpu_fall %0d after cpu_rise, expected 4", since_rise));
			if (seen_rise && (cpu_clk !== (since_rise >= 1 && since_rise <= 4)))
				mismatch($sformatf("cpu_clk is %b, %0d after cpu_rise", cpu_clk, since_rise));
			if (clk2m !== c2m_q)
			begin
				if (seen_c2m && since_c2m != 8)
					mismatch($sformatf("clk2m half period %0d, expected 8", since_c2m));
				since_c2m = 0;
				seen_c2m  = 1'b1;
				c2m_q     = clk2m;
			end
			else if (since_c2m > 9)
			begin
				mismatch("clk2m held for more than 9 cycles");
				since_c2m = 0;
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/tb_x1_io.sv
`timescale 1ns/10ps
`default_nettype none

module tb_x1_io
	import x1_io_pkg::*;
();

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_IDLE, OP_IPL} op_t;

	localparam int V_RDATA   = 0;
	localparam int V_PRINTER = 1;
	localparam int V_PORTC   = 2;	// pc7..pc4 levels
	localparam int V_STATE   = 3;	// {mmc_cs_n, sys_reset}
	localparam int V_MOSI    = 4;
	localparam int V_COUNT   = 5;

	logic  clk32M, clk_reset, ipl_n, iorq, rd, wr, miso;
	addr_t addr;
	data_t wdata, status, rdata, printer_data;
	logic  sys_reset, cpu_clk, cpu_rise, cpu_fall, clk2m, spi_busy;
	logic  lpt_stb, width40, dam_en_n, sm_scrl_n, mmc_clk, mmc_cs_n, mmc_mosi;
	logic  chk_stb;
	logic  [2:0] chk_view;
	data_t chk_exp, measured;
	int    mismatch_count;
	int    timeouts;
	integer seed;

	// stimulus table with one queue per field
	op_t   t_op[$];
	addr_t t_addr[$];
	data_t t_wdata[$];
	data_t t_miso[$];
	data_t t_exp[$];
	int    t_view[$];
	logic  t_iorq[$];

	// mmc card model state
	data_t miso_byte;
	data_t mosi_rx;
	data_t pulses;
	logic  mclk_q, busy_q;

	initial clk32M = 1'b0;
	always #50 clk32M = ~clk32M;	// 100 ns period

	x1_io_top #(.BUS_FREE(8'hff)) dut_i (
		.clk32M(clk32M), .clk_reset(clk_reset), .ipl_n(ipl_n), .addr(addr),
		.wdata(wdata), .iorq(iorq), .rd(rd), .wr(wr),
		.vblank_n(status[7]), .sub_tx_bsy(status[6]), .sub_rx_bsy(status[5]),
		.lpt_rdy(status[3]), .vsync(status[2]), .cmt_read(status[1]),
		.key_brk_n(status[0]), .miso(miso), .rdata(rdata), .sys_reset(sys_reset),
		.cpu_clk(cpu_clk), .cpu_rise(cpu_rise), .cpu_fall(cpu_fall), .clk2m(clk2m),
		.printer_data(printer_data), .lpt_stb(lpt_stb), .width40(width40),
		.dam_en_n(dam_en_n), .sm_scrl_n(sm_scrl_n), .mmc_clk(mmc_clk),
		.mmc_cs_n(mmc_cs_n), .mmc_mosi(mmc_mosi), .spi_busy(spi_busy)
	);

	x1_io_checker chk_i (
		.clk32M(clk32M), .clk_reset(clk_reset), .chk_stb(chk_stb),
		.chk_view(chk_view), .chk_exp(chk_exp), .measured(measured), .rdata(rdata),
		.printer_data(printer_data), .lpt_stb(lpt_stb), .width40(width40),
		.dam_en_n(dam_en_n), .sm_scrl_n(sm_scrl_n), .sys_reset(sys_reset),
		.mmc_cs_n(mmc_cs_n), .cpu_clk(cpu_clk), .cpu_rise(cpu_rise),
		.cpu_fall(cpu_fall), .clk2m(clk2m), .mismatch_count(mismatch_count)
	);

	// --------------------------------------------------------------------------
	// mmc card model that moves on the mmc_clk rising steps
	// --------------------------------------------------------------------------
	always @(negedge clk32M)
	begin
		if (spi_busy && !busy_q)
		begin
			pulses  = 8'd0;	// new transfer
			mosi_rx = 8'h00;
		end
		if (mmc_clk && !mclk_q)
		begin
			mosi_rx[pulses[2:0]] = mmc_mosi;	// lsb first
			pulses = pulses + 8'd1;
		end
		if (!mmc_clk)
			miso = miso_byte[pulses[2:0]];	// ready before the next rise
		mclk_q = mmc_clk;
		busy_q = spi_busy;
	end

	function automatic void add_entry(input op_t op, input addr_t a, input data_t d,
		input data_t m, input data_t e, input int v, input logic io);
		t_op.push_back(op);
		t_addr.push_back(a);
		t_wdata.push_back(d);
		t_miso.push_back(m);
		t_exp.push_back(e);
		t_view.push_back(v);
		t_iorq.push_back(io);
	endfunction

	// strobe the checker for one edge
	task automatic request_check(input int view, input data_t exp, input data_t meas);
		chk_view = view;
		chk_exp  = exp;
		measured = meas;
		chk_stb  = 1'b1;
		@(negedge clk32M);
		chk_stb  = 1'b0;
	endtask

	task automatic bus_write(input addr_t a, input data_t d, input logic io);
		addr  = a;
		wdata = d;
		iorq  = io;
		wr    = 1'b1;
		@(negedge clk32M);	// single cycle write
		iorq  = 1'b0;
		wr    = 1'b0;
	endtask

	task automatic wait_spi_idle();
		int n;
		n = 0;
		while (spi_busy && n < 64)
		begin
			@(negedge clk32M);
			n = n + 1;
		end
		if (spi_busy)
		begin
			$display("timeout: spi_busy stayed high after a transfer");
			timeouts = timeouts + 1;
		end
	endtask

	// --------------------------------------------------------------------------
	// main sequence
	// --------------------------------------------------------------------------
	initial
	begin
		int n;
		data_t pc, pc2, pa, sb, mb, ctrl;
		logic [2:0] bsel;
		seed   = 32'hce60_0cc7;
		status = $random(seed);
		pc     = $random(seed);
		pa     = $random(seed);
		sb     = $random(seed);
		mb     = $random(seed);
		bsel   = $random(seed);
		pc2    = pc;
		pc2[bsel] = ~pc[bsel];	// bit set/reset flips one chosen bit
		ctrl   = {4'h0, bsel, ~pc[bsel]};

		clk_reset = 1'b1;
		ipl_n     = 1'b1;
		addr      = 16'h0000;
		wdata     = 8'h00;
		iorq      = 1'b0;
		rd        = 1'b0;
		wr        = 1'b0;
		miso      = 1'b0;
		chk_stb   = 1'b0;
		chk_view  = 3'd0;
		chk_exp   = 8'h00;
		measured  = 8'h00;
		timeouts  = 0;
		miso_byte = 8'h00;
		mosi_rx   = 8'h00;
		pulses    = 8'd0;
		mclk_q    = 1'b0;
		busy_q    = 1'b0;

		// op, addr, wdata, miso, expected, view, iorq
		add_entry(OP_WRITE, 16'h1A02, pc, 8'h00, {4'h0, pc[7:4]}, V_PORTC, 1'b1);
		add_entry(OP_READ, 16'h1A02, 8'h00, 8'h00, pc, V_RDATA, 1'b1);
		add_entry(OP_WRITE, 16'h1A03, ctrl, 8'h00, {4'h0, pc2[7:4]}, V_PORTC, 1'b1);
		add_entry(OP_READ, 16'h1A02, 8'h00, 8'h00, pc2, V_RDATA, 1'b1);
		add_entry(OP_WRITE, 16'h1A00, pa, 8'h00, pa, V_PRINTER, 1'b1);
		add_entry(OP_READ, 16'h1A01, 8'h00, 8'h00, status | 8'h10, V_RDATA, 1'b1);
		add_entry(OP_WRITE, 16'h1A00, ~pa, 8'h00, pa, V_PRINTER, 1'b0);	// iorq low
		add_entry(OP_READ, 16'h1A02, 8'h00, 8'h00, 8'hff, V_RDATA, 1'b0);
		add_entry(OP_READ, 16'h0E00, 8'h00, 8'h00, 8'hff, V_RDATA, 1'b0);
		add_entry(OP_READ, 16'h3000, 8'h00, 8'h00, 8'hff, V_RDATA, 1'b1);	// unmapped
		add_entry(OP_WRITE, 16'h0E28, sb, mb, 8'h00, V_STATE, 1'b1);	// count 8, sel 2
		add_entry(OP_IDLE, 16'h0000, 8'h00, mb, 8'd8, V_COUNT, 1'b0);
		add_entry(OP_IDLE, 16'h0000, 8'h00, mb, sb, V_MOSI, 1'b0);
		add_entry(OP_READ, 16'h0E00, 8'h00, mb, mb, V_RDATA, 1'b1);
		add_entry(OP_WRITE, 16'h0E08, sb, mb, 8'h02, V_STATE, 1'b1);	// card not selected
		add_entry(OP_IDLE, 16'h0000, 8'h00, mb, 8'd8, V_COUNT, 1'b0);
		add_entry(OP_READ, 16'h0E00, 8'h00, mb, 8'h00, V_RDATA, 1'b1);
		add_entry(OP_WRITE, 16'h0E20, sb, 8'h00, 8'h00, V_STATE, 1'b1);	// select only, no clocks
		add_entry(OP_IPL, 16'h0000, 8'h00, 8'h00, 8'h03, V_STATE, 1'b0);
		add_entry(OP_READ, 16'h1A02, 8'h00, 8'h00, 8'h00, V_RDATA, 1'b1);
		add_entry(OP_READ, 16'h1A00, 8'h00, 8'h00, 8'h00, V_RDATA, 1'b1);
		add_entry(OP_READ, 16'h0E00, 8'h00, 8'h00, 8'h00, V_RDATA, 1'b1);	// shifter cleared

		repeat (3) @(negedge clk32M);
		clk_reset = 1'b0;
		n = 0;
		while (sys_reset === 1'b1 && n < 40)	// one rising edge per pass
		begin
			@(negedge clk32M);
			n = n + 1;
		end
		if (sys_reset !== 1'b0)
		begin
			$display("timeout: sys_reset never released after clk_reset");
			timeouts = timeouts + 1;
		end
		else
			request_check(V_COUNT, 8'd16, n);

		for (int i = 0; i < t_op.size(); i++)
		begin
			miso_byte = t_miso[i];
			case (t_op[i])
				OP_WRITE:
				begin
					bus_write(t_addr[i], t_wdata[i], t_iorq[i]);
					request_check(t_view[i], t_exp[i], 8'h00);
				end
				OP_READ:
				begin
					addr = t_addr[i];
					iorq = t_iorq[i];
					rd   = 1'b1;
					request_check(V_RDATA, t_exp[i], 8'h00);	// rdata is combinational
					iorq = 1'b0;
					rd   = 1'b0;
				end
				OP_IDLE:
				begin
					wait_spi_idle();
					request_check(t_view[i], t_exp[i], (t_view[i] == V_MOSI) ? mosi_rx : pulses);
				end
				default:
				begin
					ipl_n = 1'b0;	// button held for one cycle
					request_check(t_view[i], t_exp[i], 8'h00);
					ipl_n = 1'b1;
				end
			endcase
		end

		repeat (8) @(negedge clk32M);
		$display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeouts);
		if (mismatch_count == 0 && timeouts == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
logic/x1_io_pkg.sv
logic/clock_reset_gen.sv
logic/pia_port.sv
logic/mmc_spi_port.sv
logic/io_bus_select.sv
logic/x1_io_top.sv
verification/x1_io_checker.sv
verification/tb_x1_io.sv
